//--- term_pkg.sv
// Screen geometry, VRAM address width, command codes and reset fill character
`default_nettype none

package term_pkg;

    localparam int NUM_COLS = 60;              // Visible columns
    localparam int NUM_ROWS = 17;              // Visible rows

    localparam int COL_W    = 6;
    localparam int ROW_W    = 5;
    localparam int ADDR_W   = ROW_W + COL_W;   // Row field above column field
    localparam int CHAR_W   = 8;

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(NUM_COLS - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(NUM_ROWS - 1);

    // One-bit command code carried on i_cmd_op
    localparam logic OP_PUTCHAR   = 1'b0;
    localparam logic OP_CLEARHOME = 1'b1;

    localparam logic [CHAR_W-1:0] FILL_RESET = 8'h20;  // Space

endpackage

`default_nettype wire

//--- text_vram.sv
// Dual-port character memory, read/write port A and read-only port B
`timescale 1ns/1ns
`default_nettype none

module text_vram import term_pkg::*; (
    input  wire              i_clk,

    input  wire              i_a_en,
    input  wire              i_a_we,
    input  wire [ADDR_W-1:0] i_a_addr,
    input  wire [CHAR_W-1:0] i_a_wdata,
    output logic [CHAR_W-1:0] o_a_rdata,

    input  wire [ADDR_W-1:0] i_b_addr,
    output logic [CHAR_W-1:0] o_b_rdata
);

    logic [CHAR_W-1:0] mem [0:(1 << ADDR_W) - 1];

    // Command side
    always_ff @(posedge i_clk) begin
        if (i_a_en) begin
            if (i_a_we) begin
                mem[i_a_addr] <= i_a_wdata;
            end
            o_a_rdata <= mem[i_a_addr];  // Old data on a same-cycle write
        end
    end

    // Display side, read every cycle
    always_ff @(posedge i_clk) begin
        o_b_rdata <= mem[i_b_addr];
    end

endmodule

`default_nettype wire

//--- clear_engine.sv
// Clear engine that writes the fill character into every VRAM cell
`timescale 1ns/1ns
`default_nettype none

module clear_engine import term_pkg::*; (
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_start,
    input  wire [CHAR_W-1:0] i_fill,
    output logic              o_busy,
    output logic              o_we,
    output logic [ADDR_W-1:0] o_addr,
    output logic [CHAR_W-1:0] o_wdata
);

    logic [CHAR_W-1:0] fill_q;

    // Walks rows 0..16, all 64 column slots of each row
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_busy <= 1'b0;
            o_addr <= '0;
        end else if (i_start && !o_busy) begin
            o_busy <= 1'b1;
            o_addr <= '0;
        end else if (o_busy) begin
            if (o_addr == {LAST_ROW, {COL_W{1'b1}}}) begin
                o_busy <= 1'b0;              // Last address written
            end else begin
                o_addr <= o_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start && !o_busy) begin
            fill_q <= i_fill;                // Held for the whole pass
        end
    end

    assign o_we    = o_busy;                 // One write per cycle
    assign o_wdata = fill_q;

endmodule

`default_nettype wire

//--- scroll_engine.sv
// Scroll engine that moves rows 1..16 up one row and fills the last row
`timescale 1ns/1ns
`default_nettype none

module scroll_engine import term_pkg::*; (
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_start,
    input  wire [CHAR_W-1:0] i_fill,
    input  wire [CHAR_W-1:0] i_rdata,
    output logic              o_busy,
    output logic              o_en,
    output logic              o_we,
    output logic [ADDR_W-1:0] o_addr,
    output logic [CHAR_W-1:0] o_wdata
);

    logic [ROW_W-1:0]  row;        // Source row of the current move
    logic [COL_W-1:0]  col;
    logic              rd_phase;   // High on the read cycle of a move
    logic              filling;    // Clearing the last row
    logic [CHAR_W-1:0] fill_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_busy   <= 1'b0;
            rd_phase <= 1'b0;
            filling  <= 1'b0;
            row      <= '0;
            col      <= '0;
        end else if (i_start && !o_busy) begin
            o_busy   <= 1'b1;
            rd_phase <= 1'b1;
            filling  <= 1'b0;
            row      <= ROW_W'(1);
            col      <= '0;
        end else if (o_busy) begin
            if (filling) begin
                if (col == LAST_COL) begin
                    o_busy <= 1'b0;
                end else begin
                    col <= col + 1'b1;
                end
            end else if (rd_phase) begin
                rd_phase <= 1'b0;            // Data arrives next cycle
            end else begin
                rd_phase <= 1'b1;
                if (col == LAST_COL) begin
                    col <= '0;
                    if (row == LAST_ROW) begin
                        filling <= 1'b1;     // Row 16 stays as fill target
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start && !o_busy) begin
            fill_q <= i_fill;
        end
    end

    assign o_en    = o_busy;
    assign o_we    = o_busy && (filling || !rd_phase);
    assign o_addr  = (filling || rd_phase) ? {row, col} : {row - 1'b1, col};
    assign o_wdata = filling ? fill_q : i_rdata;  // Moved data or fill

endmodule

`default_nettype wire

//--- term_config.sv
// Configuration registers for cursor enable and fill character
`timescale 1ns/1ns
`default_nettype none

module term_config import term_pkg::*; (
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_cfg_wr,
    input  wire              i_cfg_cursor_en,
    input  wire [CHAR_W-1:0] i_cfg_fill,
    output logic              o_cursor_en,
    output logic [CHAR_W-1:0] o_fill
);

    // Settings read by the scanner and both fill engines
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cursor_en <= 1'b1;             // Cursor shown by default
            o_fill      <= FILL_RESET;
        end else if (i_cfg_wr) begin
            o_cursor_en <= i_cfg_cursor_en;
            o_fill      <= i_cfg_fill;
        end
    end

endmodule

`default_nettype wire

//--- term_control.sv
// Command handshake FSM, cursor, putchar write and VRAM port A arbitration
`timescale 1ns/1ns
`default_nettype none

module term_control import term_pkg::*; (
    input  wire              i_clk,
    input  wire              i_reset,

    input  wire              i_cmd_req,
    input  wire              i_cmd_op,
    input  wire [CHAR_W-1:0] i_cmd_char,
    output logic             o_cmd_ack,

    output logic [ROW_W-1:0] o_cursor_row,
    output logic [COL_W-1:0] o_cursor_col,

    output logic             o_clear_start,
    output logic             o_scroll_start,
    input  wire              i_clear_busy,
    input  wire              i_scroll_busy,

    input  wire              i_clear_we,
    input  wire [ADDR_W-1:0] i_clear_addr,
    input  wire [CHAR_W-1:0] i_clear_wdata,

    input  wire              i_scroll_en,
    input  wire              i_scroll_we,
    input  wire [ADDR_W-1:0] i_scroll_addr,
    input  wire [CHAR_W-1:0] i_scroll_wdata,

    output logic             o_vram_en,
    output logic             o_vram_we,
    output logic [ADDR_W-1:0] o_vram_addr,
    output logic [CHAR_W-1:0] o_vram_wdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITE,
        S_ADVANCE,
        S_WAIT_ENG,
        S_ACK,
        S_WAIT_REL
    } state_t;

    state_t state;
    logic   put_we;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state          <= S_IDLE;
            o_cursor_row   <= '0;
            o_cursor_col   <= '0;
            o_clear_start  <= 1'b0;
            o_scroll_start <= 1'b0;
        end else begin
            o_clear_start  <= 1'b0;          // Start strobes last one cycle
            o_scroll_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_cmd_req) begin
                        case (i_cmd_op)
                            OP_PUTCHAR: begin
                                state <= S_WRITE;
                            end
                            OP_CLEARHOME: begin
                                o_clear_start <= 1'b1;
                                o_cursor_row  <= '0;  // Home
                                o_cursor_col  <= '0;
                                state         <= S_WAIT_ENG;
                            end
                        endcase
                    end
                end
                S_WRITE: state <= S_ADVANCE;
                S_ADVANCE: begin
                    if (o_cursor_col == LAST_COL) begin
                        o_cursor_col <= '0;
                        if (o_cursor_row == LAST_ROW) begin
                            o_scroll_start <= 1'b1;   // Stay on row 16 and scroll
                            state          <= S_WAIT_ENG;
                        end else begin
                            o_cursor_row <= o_cursor_row + 1'b1;
                            state        <= S_ACK;
                        end
                    end else begin
                        o_cursor_col <= o_cursor_col + 1'b1;
                        state        <= S_ACK;
                    end
                end
                S_WAIT_ENG: begin
                    // Busy rises one cycle after the start pulse
                    if (!o_clear_start && !o_scroll_start &&
                        !i_clear_busy && !i_scroll_busy) begin
                        state <= S_ACK;
                    end
                end
                S_ACK:      state <= i_cmd_req ? S_WAIT_REL : S_IDLE;
                S_WAIT_REL: if (!i_cmd_req) state <= S_IDLE;
                default:    state <= S_IDLE;
            endcase
        end
    end

    assign o_cmd_ack = (state == S_ACK) || (state == S_WAIT_REL);
    assign put_we    = (state == S_WRITE);

    // Port A priority: scroll, then clear, then putchar
    always_comb begin
        if (i_scroll_busy) begin
            o_vram_en    = i_scroll_en;
            o_vram_we    = i_scroll_we;
            o_vram_addr  = i_scroll_addr;
            o_vram_wdata = i_scroll_wdata;
        end else if (i_clear_busy) begin
            o_vram_en    = i_clear_we;
            o_vram_we    = i_clear_we;
            o_vram_addr  = i_clear_addr;
            o_vram_wdata = i_clear_wdata;
        end else begin
            o_vram_en    = put_we;
            o_vram_we    = put_we;
            o_vram_addr  = {o_cursor_row, o_cursor_col};
            o_vram_wdata = i_cmd_char;
        end
    end

endmodule

`default_nettype wire

//--- text_scan.sv
// Frame scanner that reads VRAM port B and emits the cell stream
`timescale 1ns/1ns
`default_nettype none

module text_scan import term_pkg::*; (
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire [CHAR_W-1:0] i_rdata,
    input  wire              i_cursor_en,
    input  wire [ROW_W-1:0]  i_cursor_row,
    input  wire [COL_W-1:0]  i_cursor_col,
    output logic [ADDR_W-1:0] o_addr,
    output logic              o_frame_start,
    output logic              o_cell_valid,
    output logic [ROW_W-1:0]  o_cell_row,
    output logic [COL_W-1:0]  o_cell_col,
    output logic [CHAR_W-1:0] o_cell_char,
    output logic              o_cell_cursor
);

    logic             addr_active;   // Read address belongs to a frame
    logic [ROW_W-1:0] scan_row;
    logic [COL_W-1:0] scan_col;
    logic             cur_en_q;      // Cursor settings frozen per frame
    logic [ROW_W-1:0] cur_row_q;
    logic [COL_W-1:0] cur_col_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            addr_active <= 1'b0;
            scan_row    <= '0;
            scan_col    <= '0;
        end else if (!addr_active) begin
            addr_active <= 1'b1;             // Idle cycle done, start frame
            scan_row    <= '0;
            scan_col    <= '0;
        end else if (scan_col == LAST_COL) begin
            scan_col <= '0;
            if (scan_row == LAST_ROW) begin
                addr_active <= 1'b0;         // One idle cycle between frames
            end else begin
                scan_row <= scan_row + 1'b1;
            end
        end else begin
            scan_col <= scan_col + 1'b1;
        end
    end

    // Sampled in the idle cycle, so a change shows from the next frame
    always_ff @(posedge i_clk) begin
        if (!addr_active) begin
            cur_en_q  <= i_cursor_en;
            cur_row_q <= i_cursor_row;
            cur_col_q <= i_cursor_col;
        end
    end

    // Matches the one-cycle VRAM read latency
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cell_valid <= 1'b0;
        end else begin
            o_cell_valid <= addr_active;
        end
        o_cell_row    <= scan_row;
        o_cell_col    <= scan_col;
        o_cell_cursor <= cur_en_q && (scan_row == cur_row_q) && (scan_col == cur_col_q);
    end

    assign o_addr        = {scan_row, scan_col};
    assign o_frame_start = addr_active && (scan_row == '0) && (scan_col == '0);
    assign o_cell_char   = i_rdata;      // Already registered in the VRAM

endmodule

`default_nettype wire

//--- term_top.sv
// Top level of the character terminal controller
`timescale 1ns/1ns
`default_nettype none

module term_top import term_pkg::*; (
    input  wire              i_clk,
    input  wire              i_reset,

    input  wire              i_cmd_req,
    input  wire              i_cmd_op,
    input  wire [CHAR_W-1:0] i_cmd_char,
    output logic             o_cmd_ack,

    input  wire              i_cfg_wr,
    input  wire              i_cfg_cursor_en,
    input  wire [CHAR_W-1:0] i_cfg_fill,

    output logic             o_frame_start,
    output logic             o_cell_valid,
    output logic [ROW_W-1:0] o_cell_row,
    output logic [COL_W-1:0] o_cell_col,
    output logic [CHAR_W-1:0] o_cell_char,
    output logic             o_cell_cursor
);

    logic              cursor_en;
    logic [CHAR_W-1:0] fill;
    logic [ROW_W-1:0]  cursor_row;
    logic [COL_W-1:0]  cursor_col;

    logic              clear_start, clear_busy, clear_we;
    logic [ADDR_W-1:0] clear_addr;
    logic [CHAR_W-1:0] clear_wdata;

    logic              scroll_start, scroll_busy, scroll_en, scroll_we;
    logic [ADDR_W-1:0] scroll_addr;
    logic [CHAR_W-1:0] scroll_wdata;

    logic              vram_en, vram_we;
    logic [ADDR_W-1:0] vram_addr, scan_addr;
    logic [CHAR_W-1:0] vram_wdata, vram_a_rdata, vram_b_rdata;

    text_vram text_vram_i (
        .i_clk(i_clk),
        .i_a_en(vram_en), .i_a_we(vram_we), .i_a_addr(vram_addr),
        .i_a_wdata(vram_wdata), .o_a_rdata(vram_a_rdata),
        .i_b_addr(scan_addr), .o_b_rdata(vram_b_rdata)
    );

    clear_engine clear_engine_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(clear_start), .i_fill(fill),
        .o_busy(clear_busy), .o_we(clear_we), .o_addr(clear_addr), .o_wdata(clear_wdata)
    );

    scroll_engine scroll_engine_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(scroll_start), .i_fill(fill),
        .i_rdata(vram_a_rdata), .o_busy(scroll_busy), .o_en(scroll_en),
        .o_we(scroll_we), .o_addr(scroll_addr), .o_wdata(scroll_wdata)
    );

    term_config term_config_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_cfg_wr(i_cfg_wr),
        .i_cfg_cursor_en(i_cfg_cursor_en), .i_cfg_fill(i_cfg_fill),
        .o_cursor_en(cursor_en), .o_fill(fill)
    );

    term_control term_control_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_cmd_req(i_cmd_req), .i_cmd_op(i_cmd_op), .i_cmd_char(i_cmd_char),
        .o_cmd_ack(o_cmd_ack),
        .o_cursor_row(cursor_row), .o_cursor_col(cursor_col),
        .o_clear_start(clear_start), .o_scroll_start(scroll_start),
        .i_clear_busy(clear_busy), .i_scroll_busy(scroll_busy),
        .i_clear_we(clear_we), .i_clear_addr(clear_addr), .i_clear_wdata(clear_wdata),
        .i_scroll_en(scroll_en), .i_scroll_we(scroll_we),
        .i_scroll_addr(scroll_addr), .i_scroll_wdata(scroll_wdata),
        .o_vram_en(vram_en), .o_vram_we(vram_we),
        .o_vram_addr(vram_addr), .o_vram_wdata(vram_wdata)
    );

    text_scan text_scan_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_rdata(vram_b_rdata),
        .i_cursor_en(cursor_en), .i_cursor_row(cursor_row), .i_cursor_col(cursor_col),
        .o_addr(scan_addr), .o_frame_start(o_frame_start), .o_cell_valid(o_cell_valid),
        .o_cell_row(o_cell_row), .o_cell_col(o_cell_col),
        .o_cell_char(o_cell_char), .o_cell_cursor(o_cell_cursor)
    );

endmodule

`default_nettype wire

//--- term_assert.sv
// Concurrent assertions on the command handshake and VRAM port A use, bound to term_control
`timescale 1ns/1ns
`default_nettype none

module term_assert (
    input wire i_clk,
    input wire i_reset,
    input wire i_cmd_req,
    input wire i_cmd_ack,
    input wire i_clear_busy,
    input wire i_scroll_busy,
    input wire i_scroll_en,
    input wire i_scroll_we,
    input wire i_put_we
);

    int unsigned fail_count = 0;             // Read by the testbench at the end

    // Ack answers a request seen on the previous edge
    ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_cmd_ack) |-> $past(i_cmd_req))
        else begin
            fail_count++;
            $error("ack rose without a request");
        end

    ack_held: assert property (@(posedge i_clk) disable iff (i_reset)
        i_cmd_ack && i_cmd_req |=> i_cmd_ack)
        else begin
            fail_count++;
            $error("ack fell while the request was still high");
        end

    engines_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_clear_busy && i_scroll_busy))
        else begin
            fail_count++;
            $error("clear and scroll engines busy together");
        end

    // A putchar write here would lose out to the scroll in the port A mux
    no_write_on_read: assert property (@(posedge i_clk) disable iff (i_reset)
        i_scroll_busy && i_scroll_en && !i_scroll_we |-> !i_put_we)
        else begin
            fail_count++;
            $error("putchar write during a scroll read");
        end

endmodule

bind term_control term_assert term_assert_i (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_cmd_req(i_cmd_req), .i_cmd_ack(o_cmd_ack),
    .i_clear_busy(i_clear_busy), .i_scroll_busy(i_scroll_busy),
    .i_scroll_en(i_scroll_en), .i_scroll_we(i_scroll_we),
    .i_put_we(put_we)
);

`default_nettype wire

//--- tb_term.sv
// Testbench for term_top with command driver, screen model and frame checker
`timescale 1ns/1ns
`default_nettype none

module tb_term import term_pkg::*; ();

    localparam int SEED_INIT     = 9;
    localparam int NUM_RANDOM    = 100;     // First batch of characters
    localparam int NUM_SCROLL    = 1000;    // Second batch, scrolls twice
    localparam int ACK_TIMEOUT   = 5000;    // Longer than a scroll
    localparam int FRAME_TIMEOUT = 1200;
    localparam int NUM_CELLS     = NUM_ROWS * NUM_COLS;

    logic              i_clk;
    logic              i_reset;
    logic              i_cmd_req;
    logic              i_cmd_op;
    logic [CHAR_W-1:0] i_cmd_char;
    logic              o_cmd_ack;
    logic              i_cfg_wr;
    logic              i_cfg_cursor_en;
    logic [CHAR_W-1:0] i_cfg_fill;
    logic              o_frame_start;
    logic              o_cell_valid;
    logic [ROW_W-1:0]  o_cell_row;
    logic [COL_W-1:0]  o_cell_col;
    logic [CHAR_W-1:0] o_cell_char;
    logic              o_cell_cursor;

    logic [CHAR_W-1:0] shadow [NUM_ROWS][NUM_COLS];  // Expected screen
    int                model_row;
    int                model_col;
    logic              model_cursor_en;
    logic [CHAR_W-1:0] model_fill;
    integer            seed;
    logic              check_active;
    int                cells_checked;

    term_top term_top_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_cmd_req(i_cmd_req), .i_cmd_op(i_cmd_op), .i_cmd_char(i_cmd_char),
        .o_cmd_ack(o_cmd_ack),
        .i_cfg_wr(i_cfg_wr), .i_cfg_cursor_en(i_cfg_cursor_en), .i_cfg_fill(i_cfg_fill),
        .o_frame_start(o_frame_start), .o_cell_valid(o_cell_valid),
        .o_cell_row(o_cell_row), .o_cell_col(o_cell_col),
        .o_cell_char(o_cell_char), .o_cell_cursor(o_cell_cursor)
    );

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;                // 20 ns period

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int unsigned exp,
                                   input int unsigned got);
        $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
        abort_run();
    endtask

    // Character and cursor flag the screen should show at one cell
    function automatic logic [CHAR_W:0] expected_cell(input int row, input int col);
        logic cursor;
        cursor = model_cursor_en && (row == model_row) && (col == model_col);
        return {cursor, shadow[row][col]};
    endfunction

    function automatic logic [CHAR_W-1:0] random_char();
        int r;
        r = $random(seed);
        return 8'h21 + CHAR_W'($unsigned(r) % 94);   // Printable range
    endfunction

    task automatic scroll_shadow();
        for (int r = 0; r < NUM_ROWS - 1; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                shadow[r][c] = shadow[r + 1][c];
            end
        end
        for (int c = 0; c < NUM_COLS; c++) begin
            shadow[NUM_ROWS - 1][c] = model_fill;
        end
    endtask

    task automatic clear_shadow();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                shadow[r][c] = model_fill;
            end
        end
        model_row = 0;
        model_col = 0;
    endtask

    task automatic advance_model(input logic [CHAR_W-1:0] ch);
        shadow[model_row][model_col] = ch;
        if (model_col == NUM_COLS - 1) begin
            model_col = 0;
            if (model_row == NUM_ROWS - 1) begin
                scroll_shadow();              // Cursor stays on the last row
            end else begin
                model_row++;
            end
        end else begin
            model_col++;
        end
    endtask

    task automatic wait_ack(input logic level, input string what);
        int t;
        t = 0;
        do begin
            @(negedge i_clk);
            t++;
            assert (t <= ACK_TIMEOUT) else begin
                $display("Timeout while waiting for %s", what);
                abort_run();
            end
        end while (o_cmd_ack != level);
    endtask

    task automatic wait_frame_start();
        int t;
        t = 0;
        do begin
            @(negedge i_clk);
            t++;
            assert (t <= FRAME_TIMEOUT) else begin
                $display("Timeout while waiting for the start of a frame");
                abort_run();
            end
        end while (!o_frame_start);
    endtask

    // Four-phase command with a random number of extra hold cycles
    task automatic send_command(input logic op, input logic [CHAR_W-1:0] ch);
        int hold;
        assert (o_cmd_ack == 1'b0) else report_mismatch("o_cmd_ack", 0, o_cmd_ack);
        i_cmd_op   = op;
        i_cmd_char = ch;
        i_cmd_req  = 1'b1;
        wait_ack(1'b1, "the command ack");
        hold = $unsigned($random(seed)) % 3;
        repeat (hold) begin
            @(negedge i_clk);
            assert (o_cmd_ack == 1'b1) else report_mismatch("o_cmd_ack", 1, o_cmd_ack);
        end
        i_cmd_req = 1'b0;
        wait_ack(1'b0, "the ack release");
        if (op == OP_PUTCHAR) begin
            advance_model(ch);
        end else begin
            clear_shadow();
        end
    endtask

    task automatic write_config(input logic cursor_en, input logic [CHAR_W-1:0] fill);
        i_cfg_wr        = 1'b1;
        i_cfg_cursor_en = cursor_en;
        i_cfg_fill      = fill;
        @(negedge i_clk);
        i_cfg_wr        = 1'b0;
        model_cursor_en = cursor_en;
        model_fill      = fill;
    endtask

    task automatic check_next_frame();
        int t;
        wait_frame_start();
        wait_frame_start();                   // First frame wholly after the change
        cells_checked = 0;
        check_active  = 1'b1;
        t = 0;
        while (cells_checked < NUM_CELLS) begin
            @(negedge i_clk);
            t++;
            assert (t <= FRAME_TIMEOUT) else begin
                $display("Timeout while waiting for the cells of a frame");
                abort_run();
            end
        end
        check_active = 1'b0;
    endtask

    // Compares each valid cell of the frame under check with the model
    always @(negedge i_clk) begin
        logic [CHAR_W:0] exp;
        int              row;
        int              col;
        if (check_active && o_cell_valid && cells_checked < NUM_CELLS) begin
            row = cells_checked / NUM_COLS;
            col = cells_checked % NUM_COLS;
            exp = expected_cell(row, col);
            assert (o_cell_row == row) else report_mismatch("o_cell_row", row, o_cell_row);
            assert (o_cell_col == col) else report_mismatch("o_cell_col", col, o_cell_col);
            assert (o_cell_char == exp[CHAR_W-1:0])
                else report_mismatch("o_cell_char", exp[CHAR_W-1:0], o_cell_char);
            assert (o_cell_cursor == exp[CHAR_W])
                else report_mismatch("o_cell_cursor", exp[CHAR_W], o_cell_cursor);
            cells_checked++;
        end
    end

    initial begin
        seed            = SEED_INIT;
        i_reset         = 1'b1;
        i_cmd_req       = 1'b0;
        i_cmd_op        = OP_PUTCHAR;
        i_cmd_char      = '0;
        i_cfg_wr        = 1'b0;
        i_cfg_cursor_en = 1'b0;
        i_cfg_fill      = '0;
        check_active    = 1'b0;
        cells_checked   = 0;
        model_row       = 0;
        model_col       = 0;
        model_cursor_en = 1'b1;
        model_fill      = FILL_RESET;
        repeat (8) @(negedge i_clk);
        i_reset = 1'b0;

        send_command(OP_CLEARHOME, '0);       // Blank screen, cursor home
        check_next_frame();
        repeat (NUM_RANDOM) send_command(OP_PUTCHAR, random_char());
        check_next_frame();
        repeat (NUM_SCROLL) send_command(OP_PUTCHAR, random_char());
        check_next_frame();
        write_config(1'b1, 8'h2A);            // New fill then clear
        send_command(OP_CLEARHOME, '0);
        check_next_frame();
        repeat (5) send_command(OP_PUTCHAR, random_char());
        write_config(1'b0, 8'h2A);            // Cursor hidden
        check_next_frame();

        if (term_top_i.term_control_i.term_assert_i.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
term_pkg.sv
text_vram.sv
clear_engine.sv
scroll_engine.sv
term_config.sv
term_control.sv
text_scan.sv
term_top.sv
term_assert.sv
tb_term.sv

//--- Makefile
# Verilator lint, simulation and clean targets for the terminal controller

VERILATOR ?= verilator
TOP       ?= tb_term
RTL_TOP   ?= term_top
FILELIST  ?= sources.f
TB_SRCS   ?= term_assert.sv tb_term.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000000

SRCS      := $(shell cat $(FILELIST))
RTL_SRCS  := $(filter-out $(TB_SRCS),$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
